//--- flist.f
hdl/aw_mux_pkg.sv
hdl/aw_mux_stage.sv
hdl/id_remap_stage.sv
hdl/aw_spill_stage.sv
hdl/aw_mux_remap.sv
tb/aw_mux_checker.sv
tb/tb_aw_mux_remap.sv

//--- hdl/aw_mux_pkg.sv
// AW mux and ID remap definitions
`default_nettype none

package aw_mux_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned num_ports      = 4;
  localparam int unsigned port_idx_width = 2;  // Must cover num_ports
  localparam int unsigned addr_width     = 32;
  localparam int unsigned slv_id_width   = 4;  // ID at manager ports
  localparam int unsigned mux_id_width   = slv_id_width + port_idx_width;
  localparam int unsigned mst_id_width   = 4;  // Narrow downstream ID

  // AXI write response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  ////////////////////////////////////////////////////////////
  // Channel structs
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [slv_id_width-1:0] id;
    logic [addr_width-1:0]   addr;
  } slv_aw_t;

  typedef struct packed {
    logic [mux_id_width-1:0] id;  // Port index in the top bits
    logic [addr_width-1:0]   addr;
  } mux_aw_t;

  typedef struct packed {
    logic [mst_id_width-1:0] id;
    logic [addr_width-1:0]   addr;
  } mst_aw_t;

  typedef struct packed {
    logic [slv_id_width-1:0] id;
    resp_e                   resp;
  } slv_b_t;

  typedef struct packed {
    logic [mux_id_width-1:0] id;
    resp_e                   resp;
  } mux_b_t;

  typedef struct packed {
    logic [mst_id_width-1:0] id;
    resp_e                   resp;
  } mst_b_t;

endpackage

`default_nettype wire

//--- hdl/aw_mux_remap.sv
// AW multiplexer with ID remapping
`timescale 1ns/100ps
`default_nettype none

module aw_mux_remap #(
  parameter int unsigned max_uniq_ids    = 4,  // At most 2**mst_id_width
  parameter int unsigned max_txns_per_id = 3
) (
  input  wire logic                                        periph_clk,
  input  wire logic                                        arst_n_i,
  input  aw_mux_pkg::slv_aw_t [aw_mux_pkg::num_ports-1:0] slv_aw_i,
  input  wire logic [aw_mux_pkg::num_ports-1:0]            slv_aw_valid_i,
  output logic [aw_mux_pkg::num_ports-1:0]                 slv_aw_ready_o,
  output aw_mux_pkg::slv_b_t [aw_mux_pkg::num_ports-1:0]  slv_b_o,
  output logic [aw_mux_pkg::num_ports-1:0]                 slv_b_valid_o,
  input  wire logic [aw_mux_pkg::num_ports-1:0]            slv_b_ready_i,
  output aw_mux_pkg::mst_aw_t                              mst_aw_o,
  output logic                                             mst_aw_valid_o,
  input  wire logic                                        mst_aw_ready_i,
  input  aw_mux_pkg::mst_b_t                               mst_b_i,
  input  wire logic                                        mst_b_valid_i,
  output logic                                             mst_b_ready_o
);

  ////////////////////////////////////////////////////////////
  // Inter-stage channels
  ////////////////////////////////////////////////////////////

  aw_mux_pkg::mux_aw_t mux_aw;
  logic                mux_aw_valid;
  logic                mux_aw_ready;
  aw_mux_pkg::mux_b_t  mux_b;
  logic                mux_b_valid;
  logic                mux_b_ready;
  aw_mux_pkg::mst_aw_t rmp_aw;      // Remapped, before spill
  logic                rmp_aw_valid;
  logic                rmp_aw_ready;

  aw_mux_stage mux_stage_i (
    .periph_clk     ( periph_clk     ),
    .arst_n_i       ( arst_n_i       ),
    .slv_aw_i       ( slv_aw_i       ),
    .slv_aw_valid_i ( slv_aw_valid_i ),
    .slv_aw_ready_o ( slv_aw_ready_o ),
    .mux_aw_o       ( mux_aw         ),
    .mux_aw_valid_o ( mux_aw_valid   ),
    .mux_aw_ready_i ( mux_aw_ready   ),
    .mux_b_i        ( mux_b          ),
    .mux_b_valid_i  ( mux_b_valid    ),
    .mux_b_ready_o  ( mux_b_ready    ),
    .slv_b_o        ( slv_b_o        ),
    .slv_b_valid_o  ( slv_b_valid_o  ),
    .slv_b_ready_i  ( slv_b_ready_i  )
  );

  id_remap_stage #(
    .max_uniq_ids    ( max_uniq_ids    ),
    .max_txns_per_id ( max_txns_per_id )
  ) remap_stage_i (
    .periph_clk     ( periph_clk     ),
    .arst_n_i       ( arst_n_i       ),
    .mux_aw_i       ( mux_aw         ),
    .mux_aw_valid_i ( mux_aw_valid   ),
    .mux_aw_ready_o ( mux_aw_ready   ),
    .mst_aw_o       ( rmp_aw         ),
    .mst_aw_valid_o ( rmp_aw_valid   ),
    .mst_aw_ready_i ( rmp_aw_ready   ),
    .mst_b_i        ( mst_b_i        ),
    .mst_b_valid_i  ( mst_b_valid_i  ),
    .mst_b_ready_o  ( mst_b_ready_o  ),
    .mux_b_o        ( mux_b          ),
    .mux_b_valid_o  ( mux_b_valid    ),
    .mux_b_ready_i  ( mux_b_ready    )
  );

  aw_spill_stage spill_stage_i (
    .periph_clk  ( periph_clk     ),
    .arst_n_i    ( arst_n_i       ),
    .in_aw_i     ( rmp_aw         ),
    .in_valid_i  ( rmp_aw_valid   ),
    .in_ready_o  ( rmp_aw_ready   ),
    .out_aw_o    ( mst_aw_o       ),
    .out_valid_o ( mst_aw_valid_o ),
    .out_ready_i ( mst_aw_ready_i )
  );

endmodule

`default_nettype wire

//--- hdl/aw_mux_stage.sv
// Round-robin AW multiplexer
`timescale 1ns/100ps
`default_nettype none

module aw_mux_stage (
  input  wire logic                                            periph_clk,
  input  wire logic                                            arst_n_i,
  // Manager ports, AW
  input  aw_mux_pkg::slv_aw_t [aw_mux_pkg::num_ports-1:0]     slv_aw_i,
  input  wire logic [aw_mux_pkg::num_ports-1:0]                slv_aw_valid_i,
  output logic [aw_mux_pkg::num_ports-1:0]                     slv_aw_ready_o,
  // Merged AW
  output aw_mux_pkg::mux_aw_t                                  mux_aw_o,
  output logic                                                 mux_aw_valid_o,
  input  wire logic                                            mux_aw_ready_i,
  // Merged B
  input  aw_mux_pkg::mux_b_t                                   mux_b_i,
  input  wire logic                                            mux_b_valid_i,
  output logic                                                 mux_b_ready_o,
  // Manager ports, B
  output aw_mux_pkg::slv_b_t [aw_mux_pkg::num_ports-1:0]      slv_b_o,
  output logic [aw_mux_pkg::num_ports-1:0]                     slv_b_valid_o,
  input  wire logic [aw_mux_pkg::num_ports-1:0]                slv_b_ready_i
);

  localparam int unsigned np = aw_mux_pkg::num_ports;
  localparam int unsigned pw = aw_mux_pkg::port_idx_width;

  logic [pw-1:0]       prio_q;    // First port to look at
  logic                valid_q;
  aw_mux_pkg::mux_aw_t aw_q;
  logic                out_free;  // Output register can take an item
  logic                gnt_any;
  logic [pw-1:0]       gnt_idx;
  logic [np-1:0]       gnt_oh;
  logic [pw-1:0]       b_port;

  ////////////////////////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////////////////////////

  assign out_free = !valid_q || mux_aw_ready_i;

  // Walk the ports starting at the priority pointer
  always_comb begin : rr_search
    logic [pw-1:0] cand;
    gnt_any = 1'b0;
    gnt_idx = prio_q;
    for (int i = 0; i < np; i++) begin
      cand = pw'((int'(prio_q) + i) % np);
      if (!gnt_any && slv_aw_valid_i[cand]) begin
        gnt_any = 1'b1;
        gnt_idx = cand;
      end
    end
  end

  always_comb begin
    gnt_oh          = '0;
    gnt_oh[gnt_idx] = gnt_any;
  end

  assign slv_aw_ready_o = out_free ? gnt_oh : '0;

  // Control state
  always_ff @(posedge periph_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      prio_q  <= '0;                                      // Port 0 first
    end else if (out_free) begin
      valid_q <= gnt_any;
      if (gnt_any) begin
        prio_q <= pw'((int'(gnt_idx) + 1) % np);          // Skip the winner next time
      end
    end
  end

  // Payload, widened ID
  always_ff @(posedge periph_clk) begin
    if (out_free && gnt_any) begin
      aw_q.id   <= {gnt_idx, slv_aw_i[gnt_idx].id};
      aw_q.addr <= slv_aw_i[gnt_idx].addr;
    end
  end

  assign mux_aw_o       = aw_q;
  assign mux_aw_valid_o = valid_q;

  ////////////////////////////////////////////////////////////
  // B routing
  ////////////////////////////////////////////////////////////

  assign b_port = mux_b_i.id[aw_mux_pkg::mux_id_width-1 -: pw];

  always_comb begin
    for (int p = 0; p < np; p++) begin
      slv_b_o[p].id    = mux_b_i.id[aw_mux_pkg::slv_id_width-1:0];  // Strip port index
      slv_b_o[p].resp  = mux_b_i.resp;
      slv_b_valid_o[p] = mux_b_valid_i && (b_port == pw'(p));
    end
  end

  assign mux_b_ready_o = slv_b_ready_i[b_port];

endmodule

`default_nettype wire

//--- hdl/aw_spill_stage.sv
// AW output spill register
`timescale 1ns/100ps
`default_nettype none

module aw_spill_stage (
  input  wire logic           periph_clk,
  input  wire logic           arst_n_i,
  input  aw_mux_pkg::mst_aw_t in_aw_i,
  input  wire logic           in_valid_i,
  output logic                in_ready_o,
  output aw_mux_pkg::mst_aw_t out_aw_o,
  output logic                out_valid_o,
  input  wire logic           out_ready_i
);

  aw_mux_pkg::mst_aw_t main_q;
  aw_mux_pkg::mst_aw_t skid_q;
  logic                main_valid_q;
  logic                skid_valid_q;
  logic                main_load;  // Main register empty or draining
  logic                in_fire;

  assign in_ready_o = !skid_valid_q;  // Straight from a flop
  assign in_fire    = in_valid_i && in_ready_o;
  assign main_load  = !main_valid_q || out_ready_i;

  always_ff @(posedge periph_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (main_load) begin
      main_valid_q <= skid_valid_q || in_fire;
      skid_valid_q <= 1'b0;                      // Skid drains first
    end else if (in_fire) begin
      skid_valid_q <= 1'b1;                      // Main stalled, park it
    end
  end

  always_ff @(posedge periph_clk) begin
    if (main_load) begin
      main_q <= skid_valid_q ? skid_q : in_aw_i;
    end
    if (!main_load && in_fire) begin
      skid_q <= in_aw_i;
    end
  end

  assign out_aw_o    = main_q;
  assign out_valid_o = main_valid_q;

endmodule

`default_nettype wire

//--- hdl/id_remap_stage.sv
// Wide to narrow AXI ID remapper
`timescale 1ns/100ps
`default_nettype none

module id_remap_stage #(
  parameter int unsigned max_uniq_ids    = 4,
  parameter int unsigned max_txns_per_id = 3
) (
  input  wire logic          periph_clk,
  input  wire logic          arst_n_i,
  // Wide side, AW
  input  aw_mux_pkg::mux_aw_t mux_aw_i,
  input  wire logic          mux_aw_valid_i,
  output logic               mux_aw_ready_o,
  // Narrow side, AW
  output aw_mux_pkg::mst_aw_t mst_aw_o,
  output logic               mst_aw_valid_o,
  input  wire logic          mst_aw_ready_i,
  // Narrow side, B
  input  aw_mux_pkg::mst_b_t  mst_b_i,
  input  wire logic          mst_b_valid_i,
  output logic               mst_b_ready_o,
  // Wide side, B
  output aw_mux_pkg::mux_b_t  mux_b_o,
  output logic               mux_b_valid_o,
  input  wire logic          mux_b_ready_i
);

  localparam int unsigned sw = (max_uniq_ids > 1) ? $clog2(max_uniq_ids) : 1;
  localparam int unsigned cw = $clog2(max_txns_per_id + 1);
  localparam logic [cw-1:0] cnt_max = cw'(max_txns_per_id);

  // Slot table
  logic [aw_mux_pkg::mux_id_width-1:0] slot_id_q [max_uniq_ids];
  logic [cw-1:0]                       slot_cnt_q [max_uniq_ids];  // Zero means free

  logic                               hit;
  logic [sw-1:0]                      hit_slot;
  logic                               free_any;
  logic [sw-1:0]                      free_slot;
  logic [sw-1:0]                      sel_slot;
  logic                               slot_ok;
  logic [sw-1:0]                      b_slot;
  logic [max_uniq_ids-1:0]            inc_vec;
  logic [max_uniq_ids-1:0]            dec_vec;
  logic [aw_mux_pkg::mst_id_width-1:0] narrow_id;
  logic                               out_free;
  logic                               aw_fire;
  logic                               b_fire;
  logic                               valid_q;
  aw_mux_pkg::mst_aw_t                aw_q;

  ////////////////////////////////////////////////////////////
  // Slot lookup
  ////////////////////////////////////////////////////////////

  always_comb begin
    hit       = 1'b0;
    hit_slot  = '0;
    free_any  = 1'b0;
    free_slot = '0;
    for (int s = 0; s < max_uniq_ids; s++) begin
      if (!hit && slot_cnt_q[s] != '0 && slot_id_q[s] == mux_aw_i.id) begin
        hit      = 1'b1;
        hit_slot = sw'(s);
      end
    end
    // Downward walk leaves the lowest free slot
    for (int s = max_uniq_ids - 1; s >= 0; s--) begin
      if (slot_cnt_q[s] == '0) begin
        free_any  = 1'b1;
        free_slot = sw'(s);
      end
    end
  end

  assign sel_slot = hit ? hit_slot : free_slot;
  assign slot_ok  = hit ? (slot_cnt_q[hit_slot] < cnt_max) : free_any;

  always_comb begin
    narrow_id           = '0;
    narrow_id[sw-1:0]   = sel_slot;  // Slot index is the narrow ID
  end

  assign out_free       = !valid_q || mst_aw_ready_i;
  assign mux_aw_ready_o = out_free && slot_ok;
  assign aw_fire        = mux_aw_valid_i && mux_aw_ready_o;

  ////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////

  assign b_slot        = mst_b_i.id[sw-1:0];
  assign mux_b_o.id    = slot_id_q[b_slot];
  assign mux_b_o.resp  = mst_b_i.resp;
  assign mux_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = mux_b_ready_i;
  assign b_fire        = mst_b_valid_i && mux_b_ready_i;

  always_comb begin
    for (int s = 0; s < max_uniq_ids; s++) begin
      inc_vec[s] = aw_fire && (sel_slot == sw'(s));
      dec_vec[s] = b_fire && (b_slot == sw'(s));
    end
  end

  // Outstanding counts
  always_ff @(posedge periph_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int s = 0; s < max_uniq_ids; s++) begin
        slot_cnt_q[s] <= '0;
      end
    end else begin
      for (int s = 0; s < max_uniq_ids; s++) begin
        if (inc_vec[s] && !dec_vec[s]) begin
          slot_cnt_q[s] <= slot_cnt_q[s] + 1'b1;
        end else if (dec_vec[s] && !inc_vec[s]) begin
          slot_cnt_q[s] <= slot_cnt_q[s] - 1'b1;
        end
      end
    end
  end

  // Wide ID only written on allocation
  always_ff @(posedge periph_clk) begin
    if (aw_fire && !hit) begin
      slot_id_q[sel_slot] <= mux_aw_i.id;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge periph_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (out_free) begin
      valid_q <= aw_fire;
    end
  end

  always_ff @(posedge periph_clk) begin
    if (aw_fire) begin
      aw_q.id   <= narrow_id;
      aw_q.addr <= mux_aw_i.addr;
    end
  end

  assign mst_aw_o       = aw_q;
  assign mst_aw_valid_o = valid_q;

endmodule

`default_nettype wire

//--- tb/aw_mux_checker.sv
// AW mux response checker
`timescale 1ns/100ps
`default_nettype none

module aw_mux_checker #(
  parameter int unsigned max_uniq_ids    = 4,
  parameter int unsigned max_txns_per_id = 3
) (
  input  wire logic                                        periph_clk,
  input  wire logic                                        arst_n_i,
  input  aw_mux_pkg::slv_aw_t [aw_mux_pkg::num_ports-1:0] slv_aw_i,
  input  wire logic [aw_mux_pkg::num_ports-1:0]            slv_aw_valid_i,
  input  wire logic [aw_mux_pkg::num_ports-1:0]            slv_aw_ready_i,
  input  aw_mux_pkg::slv_b_t [aw_mux_pkg::num_ports-1:0]  slv_b_i,
  input  wire logic [aw_mux_pkg::num_ports-1:0]            slv_b_valid_i,
  input  wire logic [aw_mux_pkg::num_ports-1:0]            slv_b_ready_i,
  input  aw_mux_pkg::mst_aw_t                              mst_aw_i,
  input  wire logic                                        mst_aw_valid_i,
  input  wire logic                                        mst_aw_ready_i,
  input  aw_mux_pkg::mst_b_t                               mst_b_i,
  input  wire logic                                        mst_b_valid_i,
  input  wire logic                                        mst_b_ready_i,
  input  wire logic [7:0]                                  test_num_i,
  input  wire logic                                        test_done_i,
  input  wire logic                                        run_done_i,
  output int                                               err_cnt_o,
  output int                                               pending_o
);

  localparam int unsigned np    = aw_mux_pkg::num_ports;
  localparam int unsigned sw    = aw_mux_pkg::slv_id_width;
  localparam int unsigned nkeys = np << sw;   // One key per port and ID

  logic [aw_mux_pkg::addr_width-1:0]   req_q [nkeys][$];  // Waiting for B
  aw_mux_pkg::slv_aw_t                 ord_q [np][$];     // Waiting for mst_aw per port
  logic [aw_mux_pkg::mst_id_width-1:0] wide_nid [nkeys];
  int                                  wide_cnt [nkeys];
  int                                  nid_cnt [1 << aw_mux_pkg::mst_id_width];
  logic [np-1:0]                       gnt_seen [np];     // Grants while a port waits
  int err_cnt  = 0;
  int chk_cnt  = 0;
  int test_err = 0;
  int test_chk = 0;
  int n_in     = 0;
  int n_out    = 0;
  int n_resp   = 0;

  assign err_cnt_o = err_cnt;
  assign pending_o = n_in - n_resp;

  // Expected code from the two low address bits
  function automatic aw_mux_pkg::resp_e expected_resp(
    input logic [aw_mux_pkg::addr_width-1:0] addr
  );
    return aw_mux_pkg::resp_e'(addr[1:0]);
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("FAILED at %0d ns: %s expected %0h, got %0h", $time, sig, exp_v, act_v);
    err_cnt++;
  endtask

  task automatic log_error(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    err_cnt++;
  endtask

  ////////////////////////////////////////////////////////////
  // Comparison on every clock edge
  ////////////////////////////////////////////////////////////

  always @(posedge periph_clk) begin : compare
    aw_mux_pkg::slv_aw_t               exp_aw;
    logic [aw_mux_pkg::addr_width-1:0] exp_addr;
    int                                key;
    int                                p;
    if (!arst_n_i) begin
      chk_cnt++;
      if (mst_aw_valid_i || slv_b_valid_i != '0) begin
        log_error("a valid output is high during reset");
      end
      for (int q = 0; q < np; q++) begin
        gnt_seen[q] = '0;
      end
    end else begin
      // Responses first so counts drop before new issues
      for (int q = 0; q < np; q++) begin
        if (slv_b_valid_i[q] && slv_b_ready_i[q]) begin
          key = (q << sw) + slv_b_i[q].id;
          n_resp++;
          if (req_q[key].size() == 0) begin
            log_error($sformatf("response at port %0d for ID %0h with nothing outstanding",
                                q, slv_b_i[q].id));
          end else begin
            exp_addr = req_q[key].pop_front();
            chk_cnt++;
            if (slv_b_i[q].resp != expected_resp(exp_addr)) begin
              report_mismatch($sformatf("slv_b_o[%0d].resp", q), expected_resp(exp_addr),
                              slv_b_i[q].resp);
            end
            wide_cnt[key]--;
          end
        end
      end
      if (mst_b_valid_i && mst_b_ready_i) begin
        nid_cnt[mst_b_i.id]--;
      end

      for (int q = 0; q < np; q++) begin
        if (slv_aw_valid_i[q] && slv_aw_ready_i[q]) begin
          key = (q << sw) + slv_aw_i[q].id;
          req_q[key].push_back(slv_aw_i[q].addr);
          ord_q[q].push_back(slv_aw_i[q]);
          n_in++;
        end
      end

      // No port granted twice while another waits
      for (int q = 0; q < np; q++) begin
        if (!slv_aw_valid_i[q] || slv_aw_ready_i[q]) begin
          gnt_seen[q] = '0;
        end else begin
          for (int g = 0; g < np; g++) begin
            if (slv_aw_valid_i[g] && slv_aw_ready_i[g]) begin
              chk_cnt++;
              if (gnt_seen[q][g]) begin
                log_error($sformatf("port %0d granted twice while port %0d waited", g, q));
              end
              gnt_seen[q][g] = 1'b1;
            end
          end
        end
      end

      if (mst_aw_valid_i && mst_aw_ready_i) begin
        p = int'(mst_aw_i.addr[aw_mux_pkg::addr_width-1 -: aw_mux_pkg::port_idx_width]);
        n_out++;
        chk_cnt++;
        if (ord_q[p].size() == 0) begin
          log_error($sformatf("mst_aw_o address %0h matches no accepted request",
                              mst_aw_i.addr));
        end else begin
          exp_aw = ord_q[p].pop_front();
          key    = (p << sw) + exp_aw.id;
          if (exp_aw.addr != mst_aw_i.addr) begin
            report_mismatch("mst_aw_o.addr", exp_aw.addr, mst_aw_i.addr);
          end
          if (mst_aw_i.id >= max_uniq_ids) begin
            log_error($sformatf("narrow ID %0h is outside the slot table", mst_aw_i.id));
          end
          if (wide_cnt[key] != 0 && wide_nid[key] != mst_aw_i.id) begin
            report_mismatch("mst_aw_o.id", wide_nid[key], mst_aw_i.id);  // Same wide ID
          end
          wide_nid[key] = mst_aw_i.id;
          wide_cnt[key]++;
          nid_cnt[mst_aw_i.id]++;
          if (nid_cnt[mst_aw_i.id] > max_txns_per_id) begin
            log_error($sformatf("narrow ID %0h has %0d writes outstanding", mst_aw_i.id,
                                nid_cnt[mst_aw_i.id]));
          end
        end
      end
    end

    if (test_done_i) begin
      $display("Test %0d finished: %0d checks, %0d errors", test_num_i, chk_cnt - test_chk,
               err_cnt - test_err);
      test_chk = chk_cnt;
      test_err = err_cnt;
    end
    if (run_done_i) begin
      for (int k = 0; k < nkeys; k++) begin
        if (req_q[k].size() != 0) begin
          log_error($sformatf("%0d requests at key %0h never got a response",
                              req_q[k].size(), k));
        end
      end
      chk_cnt++;
      if (n_in != n_out) begin
        log_error($sformatf("%0d requests accepted but %0d left at mst_aw_o", n_in, n_out));
      end
      $display("Totals: %0d requests, %0d checks, %0d errors", n_in, chk_cnt, err_cnt);
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_aw_mux_remap.sv
// AW mux and remap testbench
`timescale 1ns/100ps
`default_nettype none

module tb_aw_mux_remap;

  localparam int unsigned np              = aw_mux_pkg::num_ports;
  localparam int unsigned idw             = aw_mux_pkg::slv_id_width;
  localparam int unsigned pw              = aw_mux_pkg::port_idx_width;
  localparam int unsigned lw              = aw_mux_pkg::addr_width - pw;
  localparam int unsigned max_uniq_ids    = 4;
  localparam int unsigned max_txns_per_id = 3;
  localparam int          total_reqs      = np * (40 + 60 + 40);  // All phases below

  logic                                        periph_clk = 1'b0;
  logic                                        arst_n_i;
  aw_mux_pkg::slv_aw_t [np-1:0]                slv_aw_i;
  logic [np-1:0]                               slv_aw_valid_i;
  logic [np-1:0]                               slv_aw_ready_o;
  aw_mux_pkg::slv_b_t [np-1:0]                 slv_b_o;
  logic [np-1:0]                               slv_b_valid_o;
  logic [np-1:0]                               slv_b_ready_i;
  aw_mux_pkg::mst_aw_t                         mst_aw_o;
  logic                                        mst_aw_valid_o;
  logic                                        mst_aw_ready_i;
  aw_mux_pkg::mst_b_t                          mst_b_i;
  logic                                        mst_b_valid_i;
  logic                                        mst_b_ready_o;
  logic [7:0]                                  test_num;
  logic                                        test_done;
  logic                                        run_done;
  int                                          err_cnt;
  int                                          pending;
  int aw_ready_pct = 100;
  int b_ready_pct  = 100;

  always #5 periph_clk = ~periph_clk;  // 10 ns period

  aw_mux_remap #(
    .max_uniq_ids    ( max_uniq_ids    ),
    .max_txns_per_id ( max_txns_per_id )
  ) aw_mux_remap_i (
    .periph_clk     ( periph_clk     ),
    .arst_n_i       ( arst_n_i       ),
    .slv_aw_i       ( slv_aw_i       ),
    .slv_aw_valid_i ( slv_aw_valid_i ),
    .slv_aw_ready_o ( slv_aw_ready_o ),
    .slv_b_o        ( slv_b_o        ),
    .slv_b_valid_o  ( slv_b_valid_o  ),
    .slv_b_ready_i  ( slv_b_ready_i  ),
    .mst_aw_o       ( mst_aw_o       ),
    .mst_aw_valid_o ( mst_aw_valid_o ),
    .mst_aw_ready_i ( mst_aw_ready_i ),
    .mst_b_i        ( mst_b_i        ),
    .mst_b_valid_i  ( mst_b_valid_i  ),
    .mst_b_ready_o  ( mst_b_ready_o  )
  );

  aw_mux_checker #(
    .max_uniq_ids    ( max_uniq_ids    ),
    .max_txns_per_id ( max_txns_per_id )
  ) checker_i (
    .periph_clk     ( periph_clk     ),
    .arst_n_i       ( arst_n_i       ),
    .slv_aw_i       ( slv_aw_i       ),
    .slv_aw_valid_i ( slv_aw_valid_i ),
    .slv_aw_ready_i ( slv_aw_ready_o ),
    .slv_b_i        ( slv_b_o        ),
    .slv_b_valid_i  ( slv_b_valid_o  ),
    .slv_b_ready_i  ( slv_b_ready_i  ),
    .mst_aw_i       ( mst_aw_o       ),
    .mst_aw_valid_i ( mst_aw_valid_o ),
    .mst_aw_ready_i ( mst_aw_ready_i ),
    .mst_b_i        ( mst_b_i        ),
    .mst_b_valid_i  ( mst_b_valid_i  ),
    .mst_b_ready_i  ( mst_b_ready_o  ),
    .test_num_i     ( test_num       ),
    .test_done_i    ( test_done      ),
    .run_done_i     ( run_done       ),
    .err_cnt_o      ( err_cnt        ),
    .pending_o      ( pending        )
  );

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Drives one manager port and holds valid until the handshake
  task automatic issue_port(input int p, input int n, input int id_span, input int gap_pct);
    for (int k = 0; k < n; k++) begin
      @(negedge periph_clk);
      slv_aw_valid_i[p] = 1'b0;
      while ($urandom_range(99) < gap_pct) begin
        @(negedge periph_clk);
      end
      slv_aw_i[p].id    = idw'($urandom_range(id_span - 1));
      slv_aw_i[p].addr  = {pw'(p), lw'($urandom())};  // Port index tags the address
      slv_aw_valid_i[p] = 1'b1;
      do begin
        @(posedge periph_clk);
      end while (!slv_aw_ready_o[p]);
    end
    @(negedge periph_clk);
    slv_aw_valid_i[p] = 1'b0;
  endtask

  task automatic end_test(input int num);
    @(negedge periph_clk);
    test_num  = 8'(num);
    test_done = 1'b1;
    @(negedge periph_clk);
    test_done = 1'b0;
  endtask

  task automatic run_phase(input int num, input int n, input int id_span, input int gap_pct,
                           input int aw_pct, input int b_pct);
    aw_ready_pct = aw_pct;
    b_ready_pct  = b_pct;
    fork
      issue_port(0, n, id_span, gap_pct);
      issue_port(1, n, id_span, gap_pct);
      issue_port(2, n, id_span, gap_pct);
      issue_port(3, n, id_span, gap_pct);
    join
    while (pending != 0) begin  // Drain all responses
      @(negedge periph_clk);
    end
    end_test(num);
  endtask

  // Downstream subordinate answering in order per narrow ID only
  initial begin : downstream
    logic [aw_mux_pkg::addr_width-1:0] pend_q [1 << aw_mux_pkg::mst_id_width][$];
    int                                cand [$];
    int                                pick;
    logic                              b_fired;
    mst_aw_ready_i = 1'b0;
    mst_b_valid_i  = 1'b0;
    mst_b_i        = '0;
    slv_b_ready_i  = '0;
    forever begin
      @(posedge periph_clk);
      b_fired = mst_b_valid_i && mst_b_ready_o;
      if (b_fired) begin
        void'(pend_q[mst_b_i.id].pop_front());
      end
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        pend_q[mst_aw_o.id].push_back(mst_aw_o.addr);
      end
      @(negedge periph_clk);
      mst_aw_ready_i = ($urandom_range(99) < aw_ready_pct);
      for (int p = 0; p < np; p++) begin
        slv_b_ready_i[p] = ($urandom_range(99) < b_ready_pct);
      end
      if (b_fired) begin
        mst_b_valid_i = 1'b0;
      end
      if (!mst_b_valid_i && $urandom_range(1) == 1) begin
        cand.delete();
        for (int n = 0; n < (1 << aw_mux_pkg::mst_id_width); n++) begin
          if (pend_q[n].size() != 0) begin
            cand.push_back(n);
          end
        end
        if (cand.size() != 0) begin
          pick          = cand[$urandom_range(cand.size() - 1)];
          mst_b_i.id    = aw_mux_pkg::mst_id_width'(pick);
          mst_b_i.resp  = aw_mux_pkg::resp_e'(pend_q[pick][0][1:0]);  // Code from address
          mst_b_valid_i = 1'b1;
        end
      end
    end
  end

  initial begin : main
    void'($urandom(30403));
    arst_n_i       = 1'b0;
    slv_aw_i       = '0;
    slv_aw_valid_i = '0;
    test_num       = '0;
    test_done      = 1'b0;
    run_done       = 1'b0;
    repeat (3) @(negedge periph_clk);
    arst_n_i = 1'b1;
    end_test(1);
    run_phase(2, 40, 16, 0, 100, 100);  // All ports busy and no stalls
    run_phase(3, 60, 16, 40, 40, 60);   // Random back-pressure
    run_phase(4, 40, 2, 20, 70, 30);    // Few wide IDs so the slot table fills
    @(negedge periph_clk);
    run_done = 1'b1;
    @(negedge periph_clk);
    run_done = 1'b0;
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (total_reqs * 50) @(posedge periph_clk);
    $display("Timeout: run did not finish within %0d cycles", total_reqs * 50);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire
